/* common/pwrCtrl_defines.svh */
// Power-shutoff controller build constants
// Domain count, settle time, register word width and register addresses

`ifndef PWRCTRL_DEFINES_SVH
`define PWRCTRL_DEFINES_SVH

// --------------------
// Sizing
// --------------------
// Number of switchable domains, one sequencer each
`define NUM_DOMAINS 4

// Cycles spent in the second power-on state before restore
`define SETTLE_CYCLES 28

// Register data word
`define REG_WIDTH 16

// --------------------
// Register addresses
// --------------------
`define ADDR_REQ    2'd0
`define ADDR_CMD    2'd1
`define ADDR_STATUS 2'd2
`define ADDR_ACK    2'd3

`endif

/* common/pwrRegPkg.sv */
// Register map types for the power controller
// Register word union with request and command views, lane positions
// and typed register addresses

`default_nettype none

`include "pwrCtrl_defines.svh"

package pwrRegPkg;

  // --------------------
  // Word layout
  // --------------------
  // Half-word lane, one byte for a 16-bit word
  localparam int laneW = `REG_WIDTH / 2;

  // Command word lanes
  localparam int cmdSetLane = 1;
  localparam int cmdClrLane = 0;

  // Status word bit positions
  // Low-power bits in the lower byte, wake-done bits in the upper byte
  localparam int statLpBase   = 0;
  localparam int statWakeBase = laneW;

  // One data word, read either as plain request bits or as set/clear masks
  typedef union packed {
    logic [`REG_WIDTH-1:0]  reqView;
    logic [1:0][laneW-1:0]  cmdView;
  } regWord_u;

  // --------------------
  // Addresses
  // --------------------
  localparam logic [1:0] addrReq    = `ADDR_REQ;
  localparam logic [1:0] addrCmd    = `ADDR_CMD;
  localparam logic [1:0] addrStatus = `ADDR_STATUS;
  localparam logic [1:0] addrAck    = `ADDR_ACK;

endpackage

`default_nettype wire

/* common/pwrSeqPkg.sv */
// Sequencer constants for the power controller
// State register width and the fifteen shutoff/restore state codes

`default_nettype none

package pwrSeqPkg;

  // State register width
  localparam int stateW = 4;

  // --------------------
  // Power-down steps
  // --------------------
  // Idle, waits for a low-power request
  localparam logic [stateW-1:0] sInit        = 4'd0;
  localparam logic [stateW-1:0] sClkOff      = 4'd1;
  localparam logic [stateW-1:0] sWait1       = 4'd2;
  localparam logic [stateW-1:0] sIsolate     = 4'd3;
  localparam logic [stateW-1:0] sSaveEdge    = 4'd4;
  localparam logic [stateW-1:0] sPrePwrOff   = 4'd5;
  // Domain off, waits for the request to drop
  localparam logic [stateW-1:0] sPwrOff      = 4'd6;

  // --------------------
  // Restore steps
  // --------------------
  localparam logic [stateW-1:0] sPwrOn1      = 4'd7;
  // Settle counter runs here
  localparam logic [stateW-1:0] sPwrOn2      = 4'd8;
  localparam logic [stateW-1:0] sRestoreEdge = 4'd9;
  localparam logic [stateW-1:0] sWait2       = 4'd10;
  localparam logic [stateW-1:0] sDeIsolate   = 4'd11;
  localparam logic [stateW-1:0] sClkOn       = 4'd12;
  localparam logic [stateW-1:0] sWait3       = 4'd13;
  localparam logic [stateW-1:0] sRstClr      = 4'd14;

endpackage

`default_nettype wire

/* pwrSeq/pwrSeqFsm.sv */
// Per-domain power-shutoff sequencer
// Next-state logic, settle counter, registered control outputs
// and status set/clear pulses

`timescale 1ns/1ps
`default_nettype none

`include "pwrCtrl_defines.svh"

module pwrSeqFsm
  import pwrSeqPkg::*;
(
  input  logic pclk6,
  input  logic nprst6,
  input  logic l1Req,
  output logic setStatus,
  output logic clrStatus,
  output logic gateClk,
  output logic isolate,
  output logic rstnNonSrpg,
  output logic saveEdge,
  output logic restoreEdge,
  output logic pwr1On,
  output logic pwr2On
);

  logic [stateW-1:0] currentState;
  logic [stateW-1:0] nextState;
  logic [4:0]        settleCnt;
  logic              rstnReg;
  logic              settleDone;

  // Last count value before leaving sPwrOn2
  assign settleDone = (settleCnt == 5'(`SETTLE_CYCLES - 1));

  // --------------------
  // Next state
  // --------------------
  always_comb
  begin
    case (currentState)
      // Start shutoff on request
      sInit:        nextState = l1Req ? sClkOff : sInit;
      sClkOff:      nextState = sWait1;
      // One cycle for the clock gate to take effect
      sWait1:       nextState = sIsolate;
      sIsolate:     nextState = sSaveEdge;
      sSaveEdge:    nextState = sPrePwrOff;
      sPrePwrOff:   nextState = sPwrOff;
      // Request release is only seen here
      sPwrOff:      nextState = l1Req ? sPwrOff : sPwrOn1;
      sPwrOn1:      nextState = sPwrOn2;
      // Hold until the rails have settled
      sPwrOn2:      nextState = settleDone ? sRestoreEdge : sPwrOn2;
      sRestoreEdge: nextState = sWait2;
      sWait2:       nextState = sDeIsolate;
      sDeIsolate:   nextState = sClkOn;
      sClkOn:       nextState = sWait3;
      // Clock running again before reset release
      sWait3:       nextState = sRstClr;
      sRstClr:      nextState = sInit;
      default:      nextState = sInit;
    endcase
  end

  // State register
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      currentState <= sInit;
    else
      currentState <= nextState;
  end

  // --------------------
  // Settle counter
  // --------------------
  // Counts cycles spent in sPwrOn2, zero elsewhere
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      settleCnt <= '0;
    else if (currentState == sPwrOn2)
      settleCnt <= settleCnt + 5'd1;
    else
      settleCnt <= '0;
  end

  // --------------------
  // Registered outputs
  // --------------------
  // Clock gated from sClkOff up to sDeIsolate
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      gateClk <= 1'b0;
    else
      gateClk <= !(nextState inside {sClkOn, sWait3, sRstClr, sInit});
  end

  // Isolation held from sIsolate through sWait2
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      isolate <= 1'b0;
    else
      isolate <= nextState inside {sIsolate, sSaveEdge, sPrePwrOff, sPwrOff,
                                   sPwrOn1, sPwrOn2, sRestoreEdge, sWait2};
  end

  // Non-retention reset held low while the domain is off or restoring
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      rstnReg <= 1'b1;
    else
      rstnReg <= nextState inside {sInit, sClkOff, sWait1, sIsolate,
                                   sSaveEdge, sPrePwrOff, sRstClr};
  end

  // Retention save strobe
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      saveEdge <= 1'b0;
    else
      saveEdge <= (nextState == sSaveEdge);
  end

  // Retention restore strobe
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      restoreEdge <= 1'b0;
    else
      restoreEdge <= (nextState == sRestoreEdge);
  end

  // Switch 1 off only in sPwrOff
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      pwr1On <= 1'b1;
    else
      pwr1On <= (nextState != sPwrOff);
  end

  // Switch 2 comes back one step after switch 1
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      pwr2On <= 1'b1;
    else
      pwr2On <= !(nextState inside {sPwrOff, sPwrOn1});
  end

  // Domain reset also follows the chip reset
  assign rstnNonSrpg = rstnReg & nprst6;

  // Status pulses, set one cycle ahead of the clock gate
  assign setStatus = (nextState == sClkOff);
  assign clrStatus = (currentState == sRstClr);

  // --------------------
  // Sequence checks
  // --------------------
  // Status pulses are mutually exclusive
  assert property (@(posedge pclk6) disable iff (!nprst6)
    !(setStatus && clrStatus));

  // Isolation follows the clock gate two cycles later
  assert property (@(posedge pclk6) disable iff (!nprst6)
    $rose(gateClk) |-> ##2 $rose(isolate));

  // Both switches open together
  assert property (@(posedge pclk6) disable iff (!nprst6)
    $fell(pwr1On) |-> $fell(pwr2On));

  // Switch 2 is on the cycle after switch 1 closes
  assert property (@(posedge pclk6) disable iff (!nprst6)
    $rose(pwr1On) |=> pwr2On);

endmodule

`default_nettype wire

/* rtl/pwrReqRegs.sv */
// Request register block
// Request register with REQ and CMD writes, ACK clear pulses
// and the registered read data path

`timescale 1ns/1ps
`default_nettype none

`include "pwrCtrl_defines.svh"

module pwrReqRegs
  import pwrRegPkg::*;
(
  input  logic                    pclk6,
  input  logic                    nprst6,
  input  logic                    wrEn,
  input  logic [1:0]              wrAddr,
  input  regWord_u                wrData,
  input  logic                    rdEn,
  input  logic [1:0]              rdAddr,
  output regWord_u                rdData,
  input  logic [`NUM_DOMAINS-1:0] lowPower,
  input  logic [`NUM_DOMAINS-1:0] wakeDone,
  output logic [`NUM_DOMAINS-1:0] l1Req,
  output logic [`NUM_DOMAINS-1:0] ackDone
);

  logic [`NUM_DOMAINS-1:0] setMask;
  logic [`NUM_DOMAINS-1:0] clrMask;
  regWord_u                rdNext;

  // Command view, upper byte sets and lower byte clears
  assign setMask = wrData.cmdView[cmdSetLane][`NUM_DOMAINS-1:0];
  assign clrMask = wrData.cmdView[cmdClrLane][`NUM_DOMAINS-1:0];

  // --------------------
  // Write side
  // --------------------
  // Request bits, clear beats set on CMD writes
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      l1Req <= '0;
    else if (wrEn)
    begin
      case (wrAddr)
        addrReq: l1Req <= wrData.reqView[`NUM_DOMAINS-1:0];
        addrCmd: l1Req <= (l1Req | setMask) & ~clrMask;
        // STATUS is read-only, ACK handled below
        default: l1Req <= l1Req;
      endcase
    end
  end

  // Write-one-to-clear on ACK, one pulse per written bit
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      ackDone <= '0;
    else if (wrEn && (wrAddr == addrAck))
      ackDone <= wrData.reqView[`NUM_DOMAINS-1:0];
    else
      ackDone <= '0;
  end

  // --------------------
  // Read side
  // --------------------
  always_comb
  begin
    rdNext = '0;
    case (rdAddr)
      addrReq:
        rdNext.reqView[`NUM_DOMAINS-1:0] = l1Req;
      addrStatus:
      begin
        rdNext.reqView[statLpBase +: `NUM_DOMAINS]   = lowPower;
        rdNext.reqView[statWakeBase +: `NUM_DOMAINS] = wakeDone;
      end
      // CMD and ACK read back as zero
      default:
        rdNext = '0;
    endcase
  end

  // Read word lands one cycle after the strobe
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      rdData <= '0;
    else if (rdEn)
      rdData <= rdNext;
  end

  // Write address must be known whenever a write is strobed
  assert property (@(posedge pclk6) disable iff (!nprst6)
    wrEn |-> !$isunknown(wrAddr));

endmodule

`default_nettype wire

/* rtl/pwrStatusRegs.sv */
// Status register block
// Per-domain low-power and sticky wake-done bits
// and the registered wake interrupt

`timescale 1ns/1ps
`default_nettype none

`include "pwrCtrl_defines.svh"

module pwrStatusRegs
(
  input  logic                    pclk6,
  input  logic                    nprst6,
  input  logic [`NUM_DOMAINS-1:0] setStatus,
  input  logic [`NUM_DOMAINS-1:0] clrStatus,
  input  logic [`NUM_DOMAINS-1:0] ackDone,
  output logic [`NUM_DOMAINS-1:0] lowPower,
  output logic [`NUM_DOMAINS-1:0] wakeDone,
  output logic                    irq
);

  logic [`NUM_DOMAINS-1:0] lowPowerNext;
  logic [`NUM_DOMAINS-1:0] wakeDoneNext;

  // --------------------
  // Next values
  // --------------------
  // Low power from the shutoff start until reset clear
  assign lowPowerNext = (lowPower | setStatus) & ~clrStatus;

  // Wake done from reset clear until software acknowledges it
  // A fresh wake in the ack cycle keeps the bit set
  assign wakeDoneNext = (wakeDone & ~ackDone) | clrStatus;

  // --------------------
  // Status bits
  // --------------------
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      lowPower <= '0;
    else
      lowPower <= lowPowerNext;
  end

  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      wakeDone <= '0;
    else
      wakeDone <= wakeDoneNext;
  end

  // Interrupt follows the stored wake bits one cycle later
  always_ff @(posedge pclk6 or negedge nprst6)
  begin
    if (!nprst6)
      irq <= 1'b0;
    else
      irq <= |wakeDone;
  end

  // No domain starts and finishes a sequence in the same cycle
  assert property (@(posedge pclk6) disable iff (!nprst6)
    (setStatus & clrStatus) == '0);

endmodule

`default_nettype wire

/* rtl/pwrCtrlTop.sv */
// Power controller top level
// Request registers, one sequencer per domain, status registers

`timescale 1ns/1ps
`default_nettype none

`include "pwrCtrl_defines.svh"

module pwrCtrlTop
  import pwrRegPkg::*;
(
  input  logic                    pclk6,
  input  logic                    nprst6,
  input  logic                    wrEn,
  input  logic [1:0]              wrAddr,
  input  regWord_u                wrData,
  input  logic                    rdEn,
  input  logic [1:0]              rdAddr,
  output regWord_u                rdData,
  output logic                    irq,
  output logic [`NUM_DOMAINS-1:0] gateClk,
  output logic [`NUM_DOMAINS-1:0] isolate,
  output logic [`NUM_DOMAINS-1:0] rstnNonSrpg,
  output logic [`NUM_DOMAINS-1:0] saveEdge,
  output logic [`NUM_DOMAINS-1:0] restoreEdge,
  output logic [`NUM_DOMAINS-1:0] pwr1On,
  output logic [`NUM_DOMAINS-1:0] pwr2On
);

  logic [`NUM_DOMAINS-1:0] l1Req;
  logic [`NUM_DOMAINS-1:0] ackDone;
  logic [`NUM_DOMAINS-1:0] lowPower;
  logic [`NUM_DOMAINS-1:0] wakeDone;
  logic [`NUM_DOMAINS-1:0] setStatus;
  logic [`NUM_DOMAINS-1:0] clrStatus;

  // --------------------
  // Register port
  // --------------------
  pwrReqRegs uReqRegs (
    .pclk6    (pclk6),
    .nprst6   (nprst6),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .wrData   (wrData),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdData   (rdData),
    .lowPower (lowPower),
    .wakeDone (wakeDone),
    .l1Req    (l1Req),
    .ackDone  (ackDone)
  );

  // --------------------
  // Sequencers
  // --------------------
  // Domain n follows request bit n
  for (genvar d = 0; d < `NUM_DOMAINS; d++)
  begin : gSeq
    pwrSeqFsm uSeq (
      .pclk6       (pclk6),
      .nprst6      (nprst6),
      .l1Req       (l1Req[d]),
      .setStatus   (setStatus[d]),
      .clrStatus   (clrStatus[d]),
      .gateClk     (gateClk[d]),
      .isolate     (isolate[d]),
      .rstnNonSrpg (rstnNonSrpg[d]),
      .saveEdge    (saveEdge[d]),
      .restoreEdge (restoreEdge[d]),
      .pwr1On      (pwr1On[d]),
      .pwr2On      (pwr2On[d])
    );
  end

  // Status collection and interrupt
  pwrStatusRegs uStatusRegs (
    .pclk6     (pclk6),
    .nprst6    (nprst6),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .ackDone   (ackDone),
    .lowPower  (lowPower),
    .wakeDone  (wakeDone),
    .irq       (irq)
  );

endmodule

`default_nettype wire

/* verification/pwrCtrlTb.sv */
// Self-checking testbench for the power controller
// Reference model functions, compare tasks, read-data checker and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "pwrCtrl_defines.svh"

module pwrCtrlTb
  import pwrRegPkg::*, pwrSeqPkg::*;
();

  localparam int settle         = `SETTLE_CYCLES;
  localparam int statHi         = `REG_WIDTH / 2;
  localparam int numTests       = 5;
  localparam int randWrites     = 4;
  localparam int testDom        = 2;
  localparam int wakeLimit      = 2 * (settle + 20);
  localparam int watchdogCycles = numTests * 2 * (settle + 20) + 200;

  // Output levels packed as {gate, iso, rstn, save, restore, pwr1, pwr2}
  localparam logic [6:0] idleLv = 7'b0010011;

  logic                    pclk6;
  logic                    nprst6;
  logic                    wrEn;
  logic [1:0]              wrAddr;
  regWord_u                wrData;
  logic                    rdEn;
  logic [1:0]              rdAddr;
  regWord_u                rdData;
  logic                    irq;
  logic [`NUM_DOMAINS-1:0] gateClk;
  logic [`NUM_DOMAINS-1:0] isolate;
  logic [`NUM_DOMAINS-1:0] rstnNonSrpg;
  logic [`NUM_DOMAINS-1:0] saveEdge;
  logic [`NUM_DOMAINS-1:0] restoreEdge;
  logic [`NUM_DOMAINS-1:0] pwr1On;
  logic [`NUM_DOMAINS-1:0] pwr2On;

  int       errCount     = 0;
  int       checkCount   = 0;
  int       testsRun     = 0;
  int       testsFailed  = 0;
  int       testErrStart = 0;
  string    curTest      = "none";
  integer   seed         = 87;
  logic     rdSeen       = 1'b0;
  regWord_u expQ[$];
  regWord_u expWord;

  pwrCtrlTop dut_i (.*);

  // --------------------
  // Reference model
  // --------------------
  // Request register after one write
  function automatic logic [`NUM_DOMAINS-1:0] nextReq(
    input logic [`NUM_DOMAINS-1:0] req,
    input logic [1:0]              addr,
    input regWord_u                data
  );
    logic [`NUM_DOMAINS-1:0] r;
    r = req;
    if (addr == `ADDR_REQ)
      r = data.reqView[`NUM_DOMAINS-1:0];
    else if (addr == `ADDR_CMD)
    begin
      // Set first, clear last, so clear wins on overlap
      r = r | data.cmdView[1][`NUM_DOMAINS-1:0];
      r = r & ~data.cmdView[0][`NUM_DOMAINS-1:0];
    end
    return r;
  endfunction

  function automatic regWord_u reqWord(input logic [`NUM_DOMAINS-1:0] bits);
    regWord_u w;
    w.reqView = '0;
    w.reqView[`NUM_DOMAINS-1:0] = bits;
    return w;
  endfunction

  // Upper byte sets, lower byte clears
  function automatic regWord_u cmdWord(input logic [`NUM_DOMAINS-1:0] setBits,
                                       input logic [`NUM_DOMAINS-1:0] clrBits);
    regWord_u w;
    w.reqView = '0;
    w.cmdView[1][`NUM_DOMAINS-1:0] = setBits;
    w.cmdView[0][`NUM_DOMAINS-1:0] = clrBits;
    return w;
  endfunction

  // Low-power in the lower byte, wake-done in the upper byte
  function automatic regWord_u statusWord(input logic [`NUM_DOMAINS-1:0] lp,
                                          input logic [`NUM_DOMAINS-1:0] wd);
    regWord_u w;
    w.reqView = '0;
    w.reqView[`NUM_DOMAINS-1:0] = lp;
    w.reqView[statHi +: `NUM_DOMAINS] = wd;
    return w;
  endfunction

  // Levels k edges after T0, k = -1 is the cycle before T0
  function automatic logic [6:0] downLevels(input int k);
    logic [6:0] lv;
    lv[6] = (k >= 0);
    lv[5] = (k >= 2);
    lv[4] = (k < 5);
    lv[3] = (k == 3);
    lv[2] = 1'b0;
    lv[1] = (k < 5);
    lv[0] = (k < 5);
    return lv;
  endfunction

  // Levels j edges after T1, restore strobe right after the settle count
  function automatic logic [6:0] wakeLevels(input int j);
    logic [6:0] lv;
    lv[6] = (j < settle + 4);
    lv[5] = (j < settle + 3);
    lv[4] = (j >= settle + 6);
    lv[3] = 1'b0;
    lv[2] = (j == settle + 1);
    lv[1] = (j >= 0);
    lv[0] = (j >= 1);
    return lv;
  endfunction

  // One domain at a given level, the rest at their idle level
  function automatic logic [`NUM_DOMAINS-1:0] domVec(input logic lvl, input logic idle,
                                                     input int d);
    logic [`NUM_DOMAINS-1:0] v;
    v = {`NUM_DOMAINS{idle}};
    v[d] = lvl;
    return v;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic checkVec(input string field, input logic [`NUM_DOMAINS-1:0] expVal,
                          input logic [`NUM_DOMAINS-1:0] actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      errCount++;
      $display("Error %s %s at %0t: expected %b actual %b",
               curTest, field, $time, expVal, actVal);
    end
  endtask

  task automatic checkBit(input string field, input logic expVal, input logic actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      errCount++;
      $display("Error %s %s at %0t: expected %b actual %b",
               curTest, field, $time, expVal, actVal);
    end
  endtask

  task automatic checkWord(input string field, input regWord_u expVal,
                           input regWord_u actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      errCount++;
      $display("Error %s %s at %0t: expected %h actual %h",
               curTest, field, $time, expVal.reqView, actVal.reqView);
    end
  endtask

  task automatic checkOuts(input logic [6:0] lv, input int d);
    checkVec("gateClk", domVec(lv[6], 1'b0, d), gateClk);
    checkVec("isolate", domVec(lv[5], 1'b0, d), isolate);
    checkVec("rstnNonSrpg", domVec(lv[4], 1'b1, d), rstnNonSrpg);
    checkVec("saveEdge", domVec(lv[3], 1'b0, d), saveEdge);
    checkVec("restoreEdge", domVec(lv[2], 1'b0, d), restoreEdge);
    checkVec("pwr1On", domVec(lv[1], 1'b1, d), pwr1On);
    checkVec("pwr2On", domVec(lv[0], 1'b1, d), pwr2On);
  endtask

  // --------------------
  // Bus and test helpers
  // --------------------
  // Returns on the edge that samples the write
  task automatic writeReg(input logic [1:0] addr, input regWord_u data);
    @(posedge pclk6);
    wrEn   <= 1'b1;
    wrAddr <= addr;
    wrData <= data;
    @(posedge pclk6);
    wrEn   <= 1'b0;
  endtask

  // Expected word is queued for the read checker
  task automatic readReg(input logic [1:0] addr, input regWord_u expVal);
    @(posedge pclk6);
    rdEn   <= 1'b1;
    rdAddr <= addr;
    expQ.push_back(expVal);
    @(posedge pclk6);
    rdEn   <= 1'b0;
    @(negedge pclk6);
  endtask

  task automatic waitIrq(input int limit);
    int n;
    n = 0;
    @(negedge pclk6);
    while ((irq !== 1'b1) && (n < limit))
    begin
      @(negedge pclk6);
      n++;
    end
    if (irq !== 1'b1)
    begin
      errCount++;
      $display("Test %s: no wake interrupt within %0d cycles", curTest, limit);
    end
  endtask

  // ackDone pulse, then wakeDone clears, then irq follows one edge later
  task automatic ackWake(input logic [`NUM_DOMAINS-1:0] mask, input logic irqAfter);
    writeReg(`ADDR_ACK, reqWord(mask));
    @(negedge pclk6);
    checkBit("irq", 1'b1, irq);
    @(negedge pclk6);
    checkBit("irq", 1'b1, irq);
    @(negedge pclk6);
    checkBit("irq", irqAfter, irq);
  endtask

  task automatic startTest(input string name);
    curTest      = name;
    testErrStart = errCount;
    testsRun++;
  endtask

  // One edge more so the read checker has seen the last read
  task automatic endTest();
    @(posedge pclk6);
    if (errCount == testErrStart)
      $display("Test %s: ok", curTest);
    else
    begin
      testsFailed++;
      $display("Test %s: FAILED with %0d errors", curTest, errCount - testErrStart);
    end
  endtask

  // --------------------
  // Clock, checker, watchdog
  // --------------------
  initial
  begin
    pclk6 = 1'b0;
    forever #50 pclk6 = ~pclk6;
  end

  // Read word is valid one edge after the strobe is sampled
  always @(posedge pclk6)
  begin
    rdSeen <= rdEn;
  end

  always @(negedge pclk6)
  begin
    if (rdSeen)
    begin
      if (expQ.size() == 0)
      begin
        errCount++;
        $display("Test %s: read data came back with no read pending", curTest);
      end
      else
      begin
        expWord = expQ.pop_front();
        checkWord("rdData", expWord, rdData);
      end
    end
  end

  initial
  begin : watchdog
    repeat (watchdogCycles) @(posedge pclk6);
    $display("Timeout: run did not finish within %0d cycles", watchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial
  begin : stimulus
    logic [31:0]             rnd;
    regWord_u                w;
    logic [1:0]              addr;
    logic [`NUM_DOMAINS-1:0] reqExp;
    logic [`NUM_DOMAINS-1:0] woke;
    nprst6 = 1'b0;
    wrEn   = 1'b0;
    wrAddr = '0;
    wrData = '0;
    rdEn   = 1'b0;
    rdAddr = '0;
    reqExp = '0;
    repeat (4) @(posedge pclk6);
    nprst6 <= 1'b1;

    startTest("reset");
    @(negedge pclk6);
    checkOuts(idleLv, 0);
    checkBit("irq", 1'b0, irq);
    readReg(`ADDR_STATUS, statusWord('0, '0));
    readReg(`ADDR_REQ, reqWord('0));
    endTest();

    startTest("req-cmd-readback");
    for (int i = 0; i < randWrites; i++)
    begin
      rnd = $random(seed);
      w.reqView = rnd[`REG_WIDTH-1:0];
      addr = (i % 2 == 0) ? `ADDR_REQ : `ADDR_CMD;
      // Set and clear masks always overlap on bit 0 and may overlap on bit 1
      if (addr == `ADDR_CMD)
      begin
        w.cmdView[1][0] = 1'b1;
        w.cmdView[0] = w.cmdView[0] | (w.cmdView[1] & 8'h03);
      end
      reqExp = nextReq(reqExp, addr, w);
      writeReg(addr, w);
      readReg(`ADDR_REQ, reqWord(reqExp));
      woke = reqExp;
      w = cmdWord('0, '1);
      writeReg(`ADDR_CMD, w);
      reqExp = nextReq(reqExp, `ADDR_CMD, w);
      // Requested domains run a full cycle before the next write
      if (woke != '0)
      begin
        waitIrq(wakeLimit);
        ackWake(woke, 1'b0);
      end
    end
    readReg(`ADDR_STATUS, statusWord('0, '0));
    endTest();

    startTest("power-down");
    reqExp = '0;
    reqExp[testDom] = 1'b1;
    writeReg(`ADDR_REQ, reqWord(reqExp));
    // First sample is the cycle before T0
    for (int k = -1; k <= 6; k++)
    begin
      @(negedge pclk6);
      checkOuts(downLevels(k), testDom);
      checkBit("irq", 1'b0, irq);
    end
    if (dut_i.gSeq[testDom].uSeq.currentState !== sPwrOff)
    begin
      errCount++;
      $display("Test %s: sequencer is not parked in the power-off state", curTest);
    end
    readReg(`ADDR_STATUS, statusWord(reqExp, '0));
    endTest();

    startTest("wake");
    writeReg(`ADDR_CMD, cmdWord('0, reqExp));
    for (int j = -1; j <= settle + 9; j++)
    begin
      @(negedge pclk6);
      checkOuts(wakeLevels(j), testDom);
      checkBit("irq", (j >= settle + 8), irq);
    end
    readReg(`ADDR_STATUS, statusWord('0, reqExp));
    endTest();

    startTest("ack-multi");
    ackWake(reqExp, 1'b0);
    readReg(`ADDR_STATUS, statusWord('0, '0));
    // Domains 0, 1 and 3 go down together, 0 wakes first
    reqExp = '0;
    reqExp[0] = 1'b1;
    reqExp[1] = 1'b1;
    reqExp[3] = 1'b1;
    writeReg(`ADDR_REQ, reqWord(reqExp));
    readReg(`ADDR_STATUS, statusWord(reqExp, '0));
    woke = '0;
    woke[0] = 1'b1;
    writeReg(`ADDR_CMD, cmdWord('0, woke));
    waitIrq(wakeLimit);
    readReg(`ADDR_STATUS, statusWord(reqExp & ~woke, woke));
    ackWake(woke, 1'b0);
    reqExp = reqExp & ~woke;
    writeReg(`ADDR_CMD, cmdWord('0, reqExp));
    waitIrq(wakeLimit);
    readReg(`ADDR_STATUS, statusWord('0, reqExp));
    ackWake(reqExp, 1'b0);
    readReg(`ADDR_STATUS, statusWord('0, '0));
    readReg(`ADDR_REQ, reqWord('0));
    endTest();

    if (expQ.size() != 0)
    begin
      errCount++;
      $display("Read data missing for %0d reads", expQ.size());
    end
    $display("Tests: %0d run, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checkCount, errCount);
    if ((errCount == 0) && (testsFailed == 0))
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/pwrRegPkg.sv
common/pwrSeqPkg.sv
pwrSeq/pwrSeqFsm.sv
rtl/pwrReqRegs.sv
rtl/pwrStatusRegs.sv
rtl/pwrCtrlTop.sv
verification/pwrCtrlTb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the power controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module pwrCtrlTb \
  -Mdir obj_dir > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/VpwrCtrlTb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
  exit 1
fi

exit 0
